/* pcs_rx_trace.txt */
# data header hdr_valid data_valid | exp_data exp_ctl exp_term exp_slip exp_lock
# Blocks 0-7 unlocked (bad header, hold-off, 4 good), block 8 onward locked
00000000 0 1 1 fefefefe f 0 1 0
00000000 0 0 1 fefefefe f 0 0 0
00000000 2 1 1 fefefefe f 0 0 0
00000000 0 0 1 fefefefe f 0 0 0
00000000 2 1 1 fefefefe f 0 0 0
00000000 0 0 1 fefefefe f 0 0 0
00000000 2 1 1 fefefefe f 0 0 0
00000000 0 0 1 fefefefe f 0 0 0
00000000 2 1 1 fefefefe f 0 0 0
00000000 0 0 1 fefefefe f 0 0 0
00000000 2 1 1 fefefefe f 0 0 0
00000000 0 0 1 fefefefe f 0 0 0
00000000 2 1 1 fefefefe f 0 0 0
00000000 0 0 1 fefefefe f 0 0 0
00000000 2 1 1 fefefefe f 0 0 0
00000000 0 0 1 fefefefe f 0 0 0
0000001e 2 1 1 07070707 f 0 0 1
00000000 0 0 1 07070707 f 0 0 1
00000078 2 1 1 000000fb 1 0 0 1
00000000 0 0 1 e0003c00 0 0 0 1
00000000 1 1 1 00000001 0 0 0 1
00000000 0 0 1 00000000 0 0 0 1
00000087 2 1 1 070707fd f 1 0 1
00000000 0 0 1 07070707 f 0 0 1
0000001c 2 1 1 07070707 f 0 0 1
00000000 0 0 1 07070707 f 0 0 1
00000078 2 1 1 000000fb 1 0 0 1
00000000 0 0 1 e0003c00 0 0 0 1
000000e0 2 1 1 000000e1 0 0 0 1
00000000 0 0 1 07fd7000 c 4 0 1
00000000 3 1 1 fefefefe f 0 0 1
00000000 0 0 1 fefefefe f 0 0 1
00000055 2 1 1 fefefefe f 0 0 1
00000000 0 0 1 fefefefe f 0 0 1
00000000 0 1 1 fefefefe f 0 0 1
00000000 0 0 1 fefefefe f 0 0 1
00000000 3 1 1 fefefefe f 0 1 0
00000000 0 0 1 fefefefe f 0 0 0
0000001e 2 1 1 fefefefe f 0 0 0
00000000 0 0 1 fefefefe f 0 0 0

/* pcs_rx.f */
pcs_rx_pkg.sv
block_lock.sv
rx_descrambler.sv
rx_decoder.sv
xgmii_rx_out.sv
pcs_rx.sv
pcs_rx_checker.sv
tb_pcs_rx.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = tb_pcs_rx
FILELIST  = pcs_rx.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check the log for a pass"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

$(BUILD_DIR)/V$(TOP): $(FILELIST) *.sv
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

test: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tb_pcs_rx.sv */
`timescale 1ns/1ps

module tb_pcs_rx
    import pcs_rx_pkg::*;
();

    typedef struct packed {
        word_t      data;
        sync_hdr_t  hdr;
        logic       hdr_valid;
        logic       data_valid;
        word_t      exp_data;
        lane_mask_t exp_ctl;
        lane_mask_t exp_term;
        logic       exp_slip;
        logic       exp_lock;
    } trace_entry_t;

    logic         xver_rx_clk = 1'b0;
    logic         rx_reset;
    word_t        rx_data;
    sync_hdr_t    rx_header;
    logic         rx_data_valid;
    logic         rx_header_valid;
    logic         slip;
    word_t        xgmii_data;
    lane_mask_t   xgmii_ctl;
    logic         xgmii_valid;
    lane_mask_t   term_loc;
    logic         block_lock;
    trace_entry_t cur;
    logic         exp_valid;
    trace_entry_t trace_q[$];
    int           value_errs;
    int           other_errs;
    int           pending;
    int           setup_errs = 0;
    int           cycle_cnt = 0;
    int           timeout_limit = 0;
    int           gap;

    always #5 xver_rx_clk = ~xver_rx_clk;

    pcs_rx #(
        .SCRAMBLER_BYPASS (0),
        .LOCK_COUNT       (4),
        .BAD_LIMIT        (2)
    ) uut (
        .xver_rx_clk            (xver_rx_clk),
        .rx_reset               (rx_reset),
        .i_xver_rx_data         (rx_data),
        .i_xver_rx_header       (rx_header),
        .i_xver_rx_data_valid   (rx_data_valid),
        .i_xver_rx_header_valid (rx_header_valid),
        .o_xver_rx_gearbox_slip (slip),
        .o_xgmii_rx_data        (xgmii_data),
        .o_xgmii_rx_ctl         (xgmii_ctl),
        .o_xgmii_rx_valid       (xgmii_valid),
        .o_term_loc             (term_loc),
        .o_block_lock           (block_lock)
    );

    pcs_rx_checker u_checker (
        .xver_rx_clk      (xver_rx_clk),
        .rx_reset         (rx_reset),
        .i_xgmii_rx_data  (xgmii_data),
        .i_xgmii_rx_ctl   (xgmii_ctl),
        .i_xgmii_rx_valid (xgmii_valid),
        .i_term_loc       (term_loc),
        .i_slip           (slip),
        .i_block_lock     (block_lock),
        .i_exp_valid      (exp_valid),
        .i_exp_data       (cur.exp_data),
        .i_exp_ctl        (cur.exp_ctl),
        .i_exp_term       (cur.exp_term),
        .i_exp_slip       (cur.exp_slip),
        .i_exp_lock       (cur.exp_lock),
        .o_value_errs     (value_errs),
        .o_other_errs     (other_errs),
        .o_pending        (pending)
    );

    assign rx_data         = cur.data;
    assign rx_header       = cur.hdr;
    assign rx_header_valid = cur.hdr_valid;
    assign rx_data_valid   = cur.data_valid;

    task automatic load_trace();
        int           fd;
        int           n;
        string        line;
        logic [31:0]  f[9];
        trace_entry_t e;
        fd = $fopen("pcs_rx_trace.txt", "r");
        if (fd == 0) begin
            setup_errs++;
            $display("Could not open the trace file pcs_rx_trace.txt");
            return;
        end
        while (!$feof(fd)) begin
            n = $fgets(line, fd);
            if (n != 0) begin
                // Comment and blank lines scan to fewer fields
                n = $sscanf(line, "%h %h %h %h %h %h %h %h %h",
                            f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8]);
                if (n == 9) begin
                    e.data       = f[0];
                    e.hdr        = f[1][1:0];
                    e.hdr_valid  = f[2][0];
                    e.data_valid = f[3][0];
                    e.exp_data   = f[4];
                    e.exp_ctl    = f[5][3:0];
                    e.exp_term   = f[6][3:0];
                    e.exp_slip   = f[7][0];
                    e.exp_lock   = f[8][0];
                    trace_q.push_back(e);
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic finish_run();
        $display("Errors: %0d value, %0d other, %0d setup", value_errs, other_errs,
                 setup_errs);
        if (value_errs == 0 && other_errs == 0 && setup_errs == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    endtask

    // Run limit scales with the trace length
    always @(posedge xver_rx_clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (timeout_limit > 0 && cycle_cnt >= timeout_limit) begin
            $display("Timeout: run did not finish within %0d cycles", timeout_limit);
            $display("Simulation FAILED");
            $finish;
        end
    end

    initial begin
        rx_reset  = 1'b1;
        cur       = '0;
        exp_valid = 1'b0;
        void'($urandom(32'ha9727e4a));
        load_trace();
        if (trace_q.size() == 0) begin
            setup_errs++;
            $display("No stimulus lines were read from the trace");
        end
        timeout_limit = 3 * trace_q.size() + 20;
        repeat (5) @(posedge xver_rx_clk);
        @(negedge xver_rx_clk);
        rx_reset = 1'b0;
        foreach (trace_q[i]) begin
            // Idle gap with both valids low
            gap = int'($urandom % 3);
            repeat (gap) begin
                @(negedge xver_rx_clk);
                cur       = '0;
                exp_valid = 1'b0;
            end
            @(negedge xver_rx_clk);
            cur       = trace_q[i];
            exp_valid = 1'b1;
        end
        @(negedge xver_rx_clk);
        cur       = '0;
        exp_valid = 1'b0;
        while (pending != 0) begin
            @(negedge xver_rx_clk);
        end
        repeat (2) @(negedge xver_rx_clk);
        finish_run();
    end

endmodule

/* pcs_rx_checker.sv */
`timescale 1ns/1ps

module pcs_rx_checker
    import pcs_rx_pkg::*;
(
    input  logic       xver_rx_clk,
    input  logic       rx_reset,
    input  word_t      i_xgmii_rx_data,
    input  lane_mask_t i_xgmii_rx_ctl,
    input  logic       i_xgmii_rx_valid,
    input  lane_mask_t i_term_loc,
    input  logic       i_slip,
    input  logic       i_block_lock,
    input  logic       i_exp_valid,
    input  word_t      i_exp_data,
    input  lane_mask_t i_exp_ctl,
    input  lane_mask_t i_exp_term,
    input  logic       i_exp_slip,
    input  logic       i_exp_lock,
    output int         o_value_errs,
    output int         o_other_errs,
    output int         o_pending
);

    typedef struct packed {
        word_t      data;
        lane_mask_t ctl;
        lane_mask_t term;
    } exp_word_t;

    exp_word_t exp_q[$];
    int        push_cnt = 0;
    int        pop_cnt = 0;
    int        value_errs = 0;
    int        other_errs = 0;
    logic      rst_q = 1'b0;
    logic      rst_q2 = 1'b0;
    logic      flags_due = 1'b0;
    logic      slip_exp_q = 1'b0;
    logic      lock_exp_q = 1'b0;

    assign o_value_errs = value_errs;
    assign o_other_errs = other_errs;
    assign o_pending    = push_cnt - pop_cnt;

    task automatic check_value(input string name, input logic [31:0] expv,
                               input logic [31:0] actv);
        if (actv !== expv) begin
            value_errs++;
            $display("Fail at %0t ns: %s expected %h, got %h", $time, name, expv, actv);
        end
    endtask

    // Capture what the DUT sees this edge
    always @(posedge xver_rx_clk) begin
        rst_q      <= rx_reset;
        rst_q2     <= rst_q;
        flags_due  <= i_exp_valid;
        slip_exp_q <= i_exp_slip;
        lock_exp_q <= i_exp_lock;
        if (i_exp_valid) begin
            exp_q.push_back({i_exp_data, i_exp_ctl, i_exp_term});
            push_cnt <= push_cnt + 1;
        end
    end

    always @(negedge xver_rx_clk) begin
        exp_word_t e;
        if (rst_q || rst_q2) begin
            check_value("o_xgmii_rx_valid", 32'(0), 32'(i_xgmii_rx_valid));
            check_value("o_xgmii_rx_data", 32'(0), i_xgmii_rx_data);
            check_value("o_xgmii_rx_ctl", 32'(0), 32'(i_xgmii_rx_ctl));
            check_value("o_term_loc", 32'(0), 32'(i_term_loc));
            check_value("o_xver_rx_gearbox_slip", 32'(0), 32'(i_slip));
            check_value("o_block_lock", 32'(0), 32'(i_block_lock));
        end
        // Slip and lock one cycle after the word that carried the header
        if (flags_due) begin
            check_value("o_xver_rx_gearbox_slip", 32'(slip_exp_q), 32'(i_slip));
            check_value("o_block_lock", 32'(lock_exp_q), 32'(i_block_lock));
        end
        if (i_xgmii_rx_valid) begin
            if (pop_cnt == push_cnt) begin
                other_errs++;
                $display("Output word at %0t ns arrived with no expected word left", $time);
            end else begin
                e = exp_q.pop_front();
                pop_cnt <= pop_cnt + 1;
                check_value("o_xgmii_rx_data", e.data, i_xgmii_rx_data);
                check_value("o_xgmii_rx_ctl", 32'(e.ctl), 32'(i_xgmii_rx_ctl));
                check_value("o_term_loc", 32'(e.term), 32'(i_term_loc));
            end
        end
    end

endmodule

/* pcs_rx.sv */
`timescale 1ns/1ps

module pcs_rx
    import pcs_rx_pkg::*;
#(
    parameter int SCRAMBLER_BYPASS = 0,
    parameter int LOCK_COUNT       = 64,
    parameter int BAD_LIMIT        = 16
) (
    input  logic       xver_rx_clk,
    input  logic       rx_reset,

    // Transceiver side, external gearbox
    input  word_t      i_xver_rx_data,
    input  sync_hdr_t  i_xver_rx_header,
    input  logic       i_xver_rx_data_valid,
    input  logic       i_xver_rx_header_valid,
    output logic       o_xver_rx_gearbox_slip,

    // XGMII side, valid is non standard
    output word_t      o_xgmii_rx_data,
    output lane_mask_t o_xgmii_rx_ctl,
    output logic       o_xgmii_rx_valid,
    output lane_mask_t o_term_loc,
    output logic       o_block_lock
);

    rx_word_t   rx_in;
    rx_word_t   rx_descr;
    word_t      dec_data;
    lane_mask_t dec_ctl;
    logic       dec_valid;

    assign rx_in.data      = i_xver_rx_data;
    assign rx_in.header    = i_xver_rx_header;
    assign rx_in.hdr_valid = i_xver_rx_header_valid;
    assign rx_in.valid     = i_xver_rx_data_valid;

    block_lock #(
        .LOCK_COUNT (LOCK_COUNT),
        .BAD_LIMIT  (BAD_LIMIT)
    ) u_block_lock (
        .xver_rx_clk  (xver_rx_clk),
        .rx_reset     (rx_reset),
        .i_header     (rx_in.header),
        .i_hdr_valid  (rx_in.hdr_valid),
        .o_slip       (o_xver_rx_gearbox_slip),
        .o_block_lock (o_block_lock)
    );

    rx_descrambler #(
        .SCRAMBLER_BYPASS (SCRAMBLER_BYPASS)
    ) u_rx_descrambler (
        .xver_rx_clk (xver_rx_clk),
        .rx_reset    (rx_reset),
        .i_word      (rx_in),
        .o_word      (rx_descr)
    );

    rx_decoder u_rx_decoder (
        .xver_rx_clk  (xver_rx_clk),
        .rx_reset     (rx_reset),
        .i_word       (rx_descr),
        .i_block_lock (o_block_lock),
        .o_data       (dec_data),
        .o_ctl        (dec_ctl),
        .o_valid      (dec_valid)
    );

    xgmii_rx_out u_xgmii_rx_out (
        .xver_rx_clk      (xver_rx_clk),
        .rx_reset         (rx_reset),
        .i_data           (dec_data),
        .i_ctl            (dec_ctl),
        .i_valid          (dec_valid),
        .o_xgmii_rx_data  (o_xgmii_rx_data),
        .o_xgmii_rx_ctl   (o_xgmii_rx_ctl),
        .o_xgmii_rx_valid (o_xgmii_rx_valid),
        .o_term_loc       (o_term_loc)
    );

endmodule

/* xgmii_rx_out.sv */
`timescale 1ns/1ps

module xgmii_rx_out
    import pcs_rx_pkg::*;
(
    input  logic       xver_rx_clk,
    input  logic       rx_reset,
    input  word_t      i_data,
    input  lane_mask_t i_ctl,
    input  logic       i_valid,
    output word_t      o_xgmii_rx_data,
    output lane_mask_t o_xgmii_rx_ctl,
    output logic       o_xgmii_rx_valid,
    output lane_mask_t o_term_loc
);

    lane_mask_t term_hit;

    // Terminate lane found here so the MAC needs no byte search
    always_comb begin
        for (int k = 0; k < DATA_NBYTES; k++) begin
            term_hit[k] = i_valid && i_ctl[k] && (i_data[8*k +: 8] == RS_TERM);
        end
    end

    always_ff @(posedge xver_rx_clk) begin
        if (rx_reset) begin
            o_xgmii_rx_data  <= '0;
            o_xgmii_rx_ctl   <= '0;
            o_xgmii_rx_valid <= 1'b0;
            o_term_loc       <= '0;
        end else begin
            o_xgmii_rx_data  <= i_data;
            o_xgmii_rx_ctl   <= i_ctl;
            o_xgmii_rx_valid <= i_valid;
            o_term_loc       <= term_hit;
        end
    end

endmodule

/* rx_decoder.sv */
`timescale 1ns/1ps

module rx_decoder
    import pcs_rx_pkg::*;
(
    input  logic       xver_rx_clk,
    input  logic       rx_reset,
    input  rx_word_t   i_word,
    input  logic       i_block_lock,
    output word_t      o_data,
    output lane_mask_t o_ctl,
    output logic       o_valid
);

    half_t      half;
    sync_hdr_t  hdr_q;
    logic [7:0] type_q;
    logic       lock_q;
    sync_hdr_t  blk_hdr;
    logic [7:0] blk_type;
    logic       blk_lock;
    logic [3:0] base;
    logic [3:0] tpos;
    logic [3:0] lane_pos;
    word_t      dec_data;
    lane_mask_t dec_ctl;

    // Number of data bytes ahead of the terminate, 8 when not a terminate type
    function automatic logic [3:0] term_pos(input logic [7:0] btype);
        case (btype)
            BT_TERM0: return 4'd0;
            BT_TERM1: return 4'd1;
            BT_TERM2: return 4'd2;
            BT_TERM3: return 4'd3;
            BT_TERM4: return 4'd4;
            BT_TERM5: return 4'd5;
            BT_TERM6: return 4'd6;
            BT_TERM7: return 4'd7;
            default:  return 4'd8;
        endcase
    endfunction

    always_comb begin
        half = i_word.hdr_valid ? FIRST : SECOND;
        if (half == FIRST) begin
            blk_hdr  = i_word.header;
            blk_type = i_word.data[7:0];
            blk_lock = i_block_lock;
            base     = 4'd0;
        end else begin
            blk_hdr  = hdr_q;
            blk_type = type_q;
            blk_lock = lock_q;
            base     = 4'd4;
        end
        tpos     = term_pos(blk_type);
        lane_pos = '0;
        dec_data = i_word.data;
        dec_ctl  = '0;

        if (!blk_lock || (blk_hdr != SYNC_DATA && blk_hdr != SYNC_CTRL)) begin
            dec_data = {DATA_NBYTES{RS_ERROR}};
            dec_ctl  = '1;
        end else if (blk_hdr == SYNC_CTRL) begin
            if (blk_type == BT_IDLE) begin
                dec_data = {DATA_NBYTES{RS_IDLE}};
                dec_ctl  = '1;
            end else if (blk_type == BT_START) begin
                // Second half of a start block is plain data
                if (half == FIRST) begin
                    dec_data[7:0] = RS_START;
                    dec_ctl[0]    = 1'b1;
                end
            end else if (tpos != 4'd8) begin
                for (int k = 0; k < DATA_NBYTES; k++) begin
                    lane_pos = base + 4'(k);
                    if (lane_pos == tpos) begin
                        dec_data[8*k +: 8] = RS_TERM;
                        dec_ctl[k]         = 1'b1;
                    end else if (lane_pos > tpos) begin
                        dec_data[8*k +: 8] = RS_IDLE;
                        dec_ctl[k]         = 1'b1;
                    end
                end
            end else begin
                dec_data = {DATA_NBYTES{RS_ERROR}};
                dec_ctl  = '1;
            end
        end
    end

    // Block context from the first half
    always_ff @(posedge xver_rx_clk) begin
        if (rx_reset) begin
            hdr_q  <= '0;
            lock_q <= 1'b0;
        end else if (i_word.valid && half == FIRST) begin
            hdr_q  <= i_word.header;
            type_q <= i_word.data[7:0];
            lock_q <= i_block_lock;
        end
    end

    always_ff @(posedge xver_rx_clk) begin
        if (rx_reset) begin
            o_data  <= '0;
            o_ctl   <= '0;
            o_valid <= 1'b0;
        end else begin
            o_valid <= i_word.valid;
            o_data  <= i_word.valid ? dec_data : '0;
            o_ctl   <= i_word.valid ? dec_ctl : '0;
        end
    end

endmodule

/* rx_descrambler.sv */
`timescale 1ns/1ps

module rx_descrambler
    import pcs_rx_pkg::*;
#(
    parameter int SCRAMBLER_BYPASS = 0
) (
    input  logic     xver_rx_clk,
    input  logic     rx_reset,
    input  rx_word_t i_word,
    output rx_word_t o_word
);

    logic [57:0] scr_q;
    logic [57:0] scr_next;
    word_t       descr;

    // x^58 + x^39 + 1, fed with the received scrambled bits
    always_comb begin
        scr_next = scr_q;
        for (int i = 0; i < DATA_WIDTH; i++) begin
            descr[i] = i_word.data[i] ^ scr_next[38] ^ scr_next[57];
            scr_next = {scr_next[56:0], i_word.data[i]};
        end
    end

    always_ff @(posedge xver_rx_clk) begin
        if (rx_reset) begin
            scr_q            <= '1;
            o_word.hdr_valid <= 1'b0;
            o_word.valid     <= 1'b0;
        end else begin
            // State only advances on real words
            if (i_word.valid) begin
                scr_q <= scr_next;
            end
            o_word.hdr_valid <= i_word.hdr_valid;
            o_word.valid     <= i_word.valid;
            o_word.header    <= i_word.header;
            if (SCRAMBLER_BYPASS != 0) begin
                o_word.data <= i_word.data;
            end else begin
                o_word.data <= descr;
            end
        end
    end

endmodule

/* block_lock.sv */
`timescale 1ns/1ps

module block_lock
    import pcs_rx_pkg::*;
#(
    parameter int LOCK_COUNT = 64,
    parameter int BAD_LIMIT  = 16
) (
    input  logic      xver_rx_clk,
    input  logic      rx_reset,
    input  sync_hdr_t i_header,
    input  logic      i_hdr_valid,
    output logic      o_slip,
    output logic      o_block_lock
);

    localparam int CNT_W = $clog2(LOCK_COUNT + 1);

    lock_state_t      state;
    logic [CNT_W-1:0] good_cnt;
    logic [CNT_W-1:0] hdr_cnt;
    logic [CNT_W-1:0] bad_cnt;
    logic [CNT_W-1:0] hold_cnt;
    logic             hdr_good;

    // Only 01 and 10 are legal sync headers
    assign hdr_good = (i_header == SYNC_DATA) || (i_header == SYNC_CTRL);

    always_ff @(posedge xver_rx_clk) begin
        if (rx_reset) begin
            state        <= LOCK_INIT;
            good_cnt     <= '0;
            hdr_cnt      <= '0;
            bad_cnt      <= '0;
            hold_cnt     <= '0;
            o_slip       <= 1'b0;
            o_block_lock <= 1'b0;
        end else begin
            o_slip <= 1'b0;
            if (i_hdr_valid) begin
                if (hold_cnt != '0) begin
                    // Gearbox is still shifting, headers are not judged
                    hold_cnt <= hold_cnt - 1'b1;
                end else begin
                    case (state)
                        LOCK_INIT, LOCK_TEST: begin
                            if (!hdr_good) begin
                                o_slip   <= 1'b1;
                                good_cnt <= '0;
                                hold_cnt <= CNT_W'(LOCK_COUNT);
                                state    <= LOCK_INIT;
                            end else if (good_cnt == CNT_W'(LOCK_COUNT - 1)) begin
                                good_cnt     <= '0;
                                hdr_cnt      <= '0;
                                bad_cnt      <= '0;
                                o_block_lock <= 1'b1;
                                state        <= LOCK_GOOD;
                            end else begin
                                good_cnt <= good_cnt + 1'b1;
                                state    <= LOCK_TEST;
                            end
                        end
                        LOCK_GOOD: begin
                            if (!hdr_good && bad_cnt == CNT_W'(BAD_LIMIT - 1)) begin
                                // Too many bad headers in this window
                                o_block_lock <= 1'b0;
                                o_slip       <= 1'b1;
                                hold_cnt     <= CNT_W'(LOCK_COUNT);
                                state        <= LOCK_INIT;
                            end else if (hdr_cnt == CNT_W'(LOCK_COUNT - 1)) begin
                                hdr_cnt <= '0;
                                bad_cnt <= '0;
                            end else begin
                                hdr_cnt <= hdr_cnt + 1'b1;
                                if (!hdr_good) begin
                                    bad_cnt <= bad_cnt + 1'b1;
                                end
                            end
                        end
                        default: begin
                            state <= LOCK_INIT;
                        end
                    endcase
                end
            end
        end
    end

endmodule

/* pcs_rx_pkg.sv */
package pcs_rx_pkg;

    // Transceiver and XGMII word geometry
    localparam int DATA_WIDTH  = 32;
    localparam int DATA_NBYTES = DATA_WIDTH / 8;

    typedef logic [DATA_WIDTH-1:0]  word_t;
    typedef logic [DATA_NBYTES-1:0] lane_mask_t;
    typedef logic [1:0]             sync_hdr_t;

    // One transceiver word with its sideband flags
    typedef struct packed {
        word_t     data;
        sync_hdr_t header;
        logic      hdr_valid;
        logic      valid;
    } rx_word_t;

    // XGMII control characters
    localparam logic [7:0] RS_IDLE  = 8'h07;
    localparam logic [7:0] RS_START = 8'hfb;
    localparam logic [7:0] RS_TERM  = 8'hfd;
    localparam logic [7:0] RS_ERROR = 8'hfe;

    // Sync headers, first received bit in bit 0
    localparam sync_hdr_t SYNC_DATA = 2'b01;
    localparam sync_hdr_t SYNC_CTRL = 2'b10;

    // Block type field of control blocks
    localparam logic [7:0] BT_IDLE  = 8'h1e;
    localparam logic [7:0] BT_START = 8'h78;
    localparam logic [7:0] BT_TERM0 = 8'h87;
    localparam logic [7:0] BT_TERM1 = 8'h99;
    localparam logic [7:0] BT_TERM2 = 8'haa;
    localparam logic [7:0] BT_TERM3 = 8'hb4;
    localparam logic [7:0] BT_TERM4 = 8'hcc;
    localparam logic [7:0] BT_TERM5 = 8'hd2;
    localparam logic [7:0] BT_TERM6 = 8'he1;
    localparam logic [7:0] BT_TERM7 = 8'hff;

    typedef enum logic [1:0] {
        LOCK_INIT,
        LOCK_TEST,
        LOCK_GOOD
    } lock_state_t;

    typedef enum logic {
        FIRST,
        SECOND
    } half_t;

endpackage
